// ==== verilog/i2s_pkg.sv ====
package i2s_pkg;

  // --------------------------------------------------
  // frame and buffer constants
  // --------------------------------------------------
  localparam int sample_w      = 16;
  localparam int fifo_depth    = 64;
  localparam int fifo_addr_w   = 6;
  // clk cycles per bclk half period
  localparam int bclk_div      = 2;
  localparam int bits_per_half = sample_w;
  // pin levels trail the internal edge strobes by this many clk
  localparam int level_delay   = 3;

  typedef logic [sample_w-1:0]  sample_t;
  typedef logic [fifo_addr_w-1:0] fifo_addr_t;
  // one extra bit so a full buffer can be told from an empty one
  typedef logic [fifo_addr_w:0]   fifo_count_t;
  typedef logic [0:0]             div_count_t;
  typedef logic [3:0]             bit_count_t;

  typedef struct packed {
    logic bclk;
    logic lrclk;
    logic bclk_rise;
    logic bclk_fall;
    logic lrclk_rise;
    logic lrclk_fall;
  } i2s_timing_t;

  typedef enum logic [2:0] {
    idle,
    start_sample,
    start_left,
    transfer_left,
    start_right,
    transfer_right
  } frame_state_e;

  typedef struct packed {
    logic load_new;
    logic load_valid;
    logic reload;
    logic shift;
  } shift_ctrl_t;

endpackage

// ==== verilog/i2s_clock_gen.sv ====
`timescale 1ns/10ps

module i2s_clock_gen (
  input  logic                clk,
  input  logic                reset_n,
  output i2s_pkg::i2s_timing_t timing
);

  i2s_pkg::div_count_t div_cnt;
  i2s_pkg::bit_count_t bit_cnt;
  logic                bclk_int;
  logic                lrclk_int;

  // delay line for {lrclk, bclk}, stage 0 doubles as the edge reference
  logic [i2s_pkg::level_delay-1:0][1:0] level_q;

  // --------------------------------------------------
  // dividers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      div_cnt   <= '0;
      bit_cnt   <= '0;
      bclk_int  <= 1'b0;
      lrclk_int <= 1'b0;
    end else if (div_cnt == i2s_pkg::div_count_t'(i2s_pkg::bclk_div - 1)) begin
      div_cnt  <= '0;
      bclk_int <= ~bclk_int;
      // count falling bclk edges, lrclk flips on the last one of a half
      if (bclk_int) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == i2s_pkg::bit_count_t'(i2s_pkg::bits_per_half - 1)) begin
          lrclk_int <= ~lrclk_int;
        end
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // --------------------------------------------------
  // level pipeline
  // --------------------------------------------------
  // the strobes lead the pins, which leaves the serializer time to load
  // and register each bit before the matching bclk rise
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      level_q <= '0;
    end else begin
      level_q <= {level_q[i2s_pkg::level_delay-2:0], {lrclk_int, bclk_int}};
    end
  end

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------
  assign timing.bclk       = level_q[i2s_pkg::level_delay-1][0];
  assign timing.lrclk      = level_q[i2s_pkg::level_delay-1][1];
  assign timing.bclk_rise  = bclk_int & ~level_q[0][0];
  assign timing.bclk_fall  = ~bclk_int & level_q[0][0];
  assign timing.lrclk_rise = lrclk_int & ~level_q[0][1];
  assign timing.lrclk_fall = ~lrclk_int & level_q[0][1];

endmodule

// ==== verilog/sample_fifo.sv ====
`timescale 1ns/10ps

module sample_fifo (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             clr,
  input  logic             push,
  input  i2s_pkg::sample_t push_data,
  input  logic             pop,
  output i2s_pkg::sample_t pop_data,
  output logic             full,
  output logic             empty
);

  i2s_pkg::sample_t     mem [i2s_pkg::fifo_depth];
  i2s_pkg::fifo_addr_t  wr_ptr;
  i2s_pkg::fifo_addr_t  rd_ptr;
  i2s_pkg::fifo_count_t count;
  logic                 do_push;

  // writes into a full buffer are lost
  assign do_push = push & ~full & ~clr;

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n || clr) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // pop is only raised by the FSM when not empty
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // read word valid the cycle after pop
  always_ff @(posedge clk) begin
    if (pop) begin
      pop_data <= mem[rd_ptr];
    end
  end

  assign full  = (count == i2s_pkg::fifo_count_t'(i2s_pkg::fifo_depth));
  assign empty = (count == '0);

endmodule

// ==== verilog/i2s_frame_fsm.sv ====
`timescale 1ns/10ps

module i2s_frame_fsm (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 en,
  input  i2s_pkg::i2s_timing_t timing,
  input  logic                 fifo_empty,
  output logic                 pop,
  output i2s_pkg::shift_ctrl_t ctrl
);

  i2s_pkg::frame_state_e state;
  i2s_pkg::frame_state_e state_nxt;
  // sample popped this frame, else the frame goes out as zeros
  logic                  popped;

  // --------------------------------------------------
  // state register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= i2s_pkg::idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      i2s_pkg::idle: begin
        // wait for a frame boundary before starting
        if (timing.lrclk_rise && timing.bclk_fall) begin
          state_nxt = i2s_pkg::start_sample;
        end
      end
      i2s_pkg::start_sample: state_nxt = i2s_pkg::start_left;
      i2s_pkg::start_left:   state_nxt = i2s_pkg::transfer_left;
      i2s_pkg::transfer_left: begin
        if (timing.lrclk_fall) begin
          state_nxt = i2s_pkg::start_right;
        end
      end
      i2s_pkg::start_right:  state_nxt = i2s_pkg::transfer_right;
      i2s_pkg::transfer_right: begin
        if (timing.lrclk_rise) begin
          state_nxt = i2s_pkg::start_sample;
        end
      end
      default: state_nxt = i2s_pkg::idle;
    endcase
  end

  // --------------------------------------------------
  // fifo read
  // --------------------------------------------------
  assign pop = (state == i2s_pkg::start_sample) && en && !fifo_empty;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      popped <= 1'b0;
    end else if (state == i2s_pkg::start_sample) begin
      popped <= pop;
    end
  end

  // shifter commands
  always_comb begin
    ctrl            = '0;
    ctrl.load_new   = (state == i2s_pkg::start_left);
    ctrl.load_valid = (state == i2s_pkg::start_left) && popped;
    ctrl.reload     = (state == i2s_pkg::start_right);
    ctrl.shift      = (state == i2s_pkg::transfer_left) ||
                      (state == i2s_pkg::transfer_right);
  end

endmodule

// ==== verilog/sample_shifter.sv ====
`timescale 1ns/10ps

module sample_shifter (
  input  logic                 clk,
  input  logic                 reset_n,
  input  i2s_pkg::i2s_timing_t timing,
  input  i2s_pkg::shift_ctrl_t ctrl,
  input  i2s_pkg::sample_t     load_data,
  output logic                 i2s_data
);

  // hold keeps the sample for the right half
  i2s_pkg::sample_t hold_q;
  i2s_pkg::sample_t shift_q;
  i2s_pkg::sample_t load_word;

  // missing sample goes out as silence
  assign load_word = ctrl.load_valid ? load_data : '0;

  always_ff @(posedge clk) begin
    if (ctrl.load_new) begin
      hold_q <= load_word;
    end
  end

  // --------------------------------------------------
  // shift register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      shift_q <= '0;
    end else if (ctrl.load_new) begin
      shift_q <= load_word;
    end else if (ctrl.reload) begin
      shift_q <= hold_q;
    end else if (ctrl.shift && timing.bclk_fall) begin
      // msb first, zero fill
      shift_q <= {shift_q[i2s_pkg::sample_w-2:0], 1'b0};
    end
  end

  // serial output, one clk behind the msb
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      i2s_data <= 1'b0;
    end else begin
      i2s_data <= shift_q[i2s_pkg::sample_w-1];
    end
  end

endmodule

// ==== verilog/i2s_tx.sv ====
`timescale 1ns/10ps

module i2s_tx (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             en,
  input  logic             fifo_clr,
  input  logic             wr_en,
  input  i2s_pkg::sample_t wr_data,
  output logic             fifo_full,
  output logic             fifo_empty,
  output logic             bclk,
  output logic             lrclk,
  output logic             i2s_data
);

  i2s_pkg::i2s_timing_t timing;
  i2s_pkg::shift_ctrl_t ctrl;
  i2s_pkg::sample_t     fifo_rd_data;
  logic                 fifo_pop;

  // --------------------------------------------------
  // clocking
  // --------------------------------------------------
  i2s_clock_gen u_clock_gen (
    .clk     (clk),
    .reset_n (reset_n),
    .timing  (timing)
  );

  assign bclk  = timing.bclk;
  assign lrclk = timing.lrclk;

  // --------------------------------------------------
  // sample buffer
  // --------------------------------------------------
  sample_fifo u_fifo (
    .clk       (clk),
    .reset_n   (reset_n),
    .clr       (fifo_clr),
    .push      (wr_en),
    .push_data (wr_data),
    .pop       (fifo_pop),
    .pop_data  (fifo_rd_data),
    .full      (fifo_full),
    .empty     (fifo_empty)
  );

  // --------------------------------------------------
  // frame control and serializer
  // --------------------------------------------------
  i2s_frame_fsm u_frame_fsm (
    .clk        (clk),
    .reset_n    (reset_n),
    .en         (en),
    .timing     (timing),
    .fifo_empty (fifo_empty),
    .pop        (fifo_pop),
    .ctrl       (ctrl)
  );

  sample_shifter u_shifter (
    .clk       (clk),
    .reset_n   (reset_n),
    .timing    (timing),
    .ctrl      (ctrl),
    .load_data (fifo_rd_data),
    .i2s_data  (i2s_data)
  );

endmodule

// ==== test/i2s_tx_tb.sv ====
`timescale 1ns/10ps

module i2s_tx_tb;

  logic             clk;
  logic             reset_n;
  logic             en;
  logic             fifo_clr;
  logic             wr_en;
  i2s_pkg::sample_t wr_data;
  logic             fifo_full;
  logic             fifo_empty;
  logic             bclk;
  logic             lrclk;
  logic             i2s_data;

  // samples expected from the fifo in write order
  i2s_pkg::sample_t model_q[$];
  logic [31:0]      lfsr_state;

  i2s_tx u_i2s_tx (
    .clk        (clk),
    .reset_n    (reset_n),
    .en         (en),
    .fifo_clr   (fifo_clr),
    .wr_en      (wr_en),
    .wr_data    (wr_data),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .bclk       (bclk),
    .lrclk      (lrclk),
    .i2s_data   (i2s_data)
  );

  always #2 clk = ~clk;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_equal(input string what, input int got, input int expected);
    assert (got == expected) else begin
      $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
      $display("Some tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("Some tests failed");
    $fatal(1, "timeout");
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_sample(output i2s_pkg::sample_t s);
    s = '0;
    for (int i = 0; i < i2s_pkg::sample_w; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      s = {s[i2s_pkg::sample_w-2:0], lfsr_state[0]};
    end
  endtask

  task automatic wait_bclk_rise(output int cycles);
    logic prev;
    cycles = 0;
    do begin
      prev = bclk;
      next_cycle();
      cycles++;
      if (cycles > 4 * i2s_pkg::bclk_div) fail_timeout("a bclk rising edge");
    end while (!(bclk && !prev));
  endtask

  task automatic wait_lrclk_edge(input logic level, output int cycles);
    logic prev;
    cycles = 0;
    do begin
      prev = lrclk;
      next_cycle();
      cycles++;
      if (cycles > 6 * i2s_pkg::bclk_div * i2s_pkg::bits_per_half) begin
        fail_timeout("an lrclk edge");
      end
    end while (!(lrclk == level && prev != level));
  endtask

  // one bit per bclk rise starting with the msb
  task automatic receive_half(output i2s_pkg::sample_t word);
    int cycles;
    word = '0;
    for (int k = 0; k < i2s_pkg::sample_w; k++) begin
      wait_bclk_rise(cycles);
      word = {word[i2s_pkg::sample_w-2:0], i2s_data};
    end
  endtask

  task automatic expect_frame(input i2s_pkg::sample_t expected);
    i2s_pkg::sample_t word;
    int               cycles;
    wait_lrclk_edge(1'b1, cycles);
    receive_half(word);
    check_equal("left half", int'(word), int'(expected));
    wait_lrclk_edge(1'b0, cycles);
    receive_half(word);
    check_equal("right half", int'(word), int'(expected));
  endtask

  task automatic expect_sample();
    i2s_pkg::sample_t expected;
    check_equal("model queue not empty", int'(model_q.size() > 0), 1);
    expected = model_q.pop_front();
    expect_frame(expected);
  endtask

  // lrclk fall half a frame ahead of the next pop
  task automatic sync_frame();
    int cycles;
    wait_lrclk_edge(1'b0, cycles);
  endtask

  task automatic write_sample(input i2s_pkg::sample_t s);
    wr_en = 1'b1;
    wr_data = s;
    next_cycle();
    wr_en = 1'b0;
    // full buffer drops the write
    if (model_q.size() < i2s_pkg::fifo_depth) model_q.push_back(s);
  endtask

  task automatic write_random(input int n);
    i2s_pkg::sample_t s;
    for (int i = 0; i < n; i++) begin
      next_sample(s);
      write_sample(s);
    end
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  task automatic test_reset_values();
    int cycles;
    check_equal("bclk", int'(bclk), 0);
    check_equal("lrclk", int'(lrclk), 0);
    check_equal("i2s_data", int'(i2s_data), 0);
    check_equal("fifo_empty", int'(fifo_empty), 1);
    check_equal("fifo_full", int'(fifo_full), 0);
    wait_bclk_rise(cycles);
    wait_bclk_rise(cycles);
    check_equal("bclk period", cycles, 2 * i2s_pkg::bclk_div);
    wait_lrclk_edge(1'b1, cycles);
    wait_lrclk_edge(1'b0, cycles);
    check_equal("lrclk high time", cycles, 2 * i2s_pkg::bclk_div * i2s_pkg::bits_per_half);
    wait_lrclk_edge(1'b1, cycles);
    check_equal("lrclk low time", cycles, 2 * i2s_pkg::bclk_div * i2s_pkg::bits_per_half);
  endtask

  task automatic test_single_sample();
    en = 1'b1;
    sync_frame();
    write_random(1);
    expect_sample();
    check_equal("fifo_empty after single", int'(fifo_empty), 1);
  endtask

  task automatic test_stream();
    sync_frame();
    write_random(8);
    repeat (8) expect_sample();
    check_equal("fifo_empty after stream", int'(fifo_empty), 1);
  endtask

  task automatic test_zero_frames();
    sync_frame();
    expect_frame('0);
    en = 1'b0;
    write_random(1);
    sync_frame();
    repeat (2) expect_frame('0);
    check_equal("fifo_empty with en low", int'(fifo_empty), 0);
    sync_frame();
    en = 1'b1;
    expect_sample();
  endtask

  task automatic test_full();
    en = 1'b0;
    write_random(i2s_pkg::fifo_depth);
    check_equal("fifo_full", int'(fifo_full), 1);
    write_random(1);
    check_equal("fifo_full after dropped write", int'(fifo_full), 1);
    sync_frame();
    en = 1'b1;
    repeat (i2s_pkg::fifo_depth) expect_sample();
    check_equal("fifo_empty after drain", int'(fifo_empty), 1);
  endtask

  task automatic test_clear();
    en = 1'b0;
    write_random(5);
    check_equal("fifo_empty before clear", int'(fifo_empty), 0);
    fifo_clr = 1'b1;
    next_cycle();
    fifo_clr = 1'b0;
    model_q.delete();
    check_equal("fifo_empty after clear", int'(fifo_empty), 1);
    en = 1'b1;
    sync_frame();
    repeat (2) expect_frame('0);
  endtask

  initial begin
    clk = 1'b0;
    reset_n = 1'b0;
    en = 1'b0;
    fifo_clr = 1'b0;
    wr_en = 1'b0;
    wr_data = '0;
    lfsr_state = 32'h1a5b;
    repeat (4) @(posedge clk);
    #1;
    reset_n = 1'b1;
    test_reset_values();
    test_single_sample();
    test_stream();
    test_zero_frames();
    test_full();
    test_clear();
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== sources.f ====
verilog/i2s_pkg.sv
verilog/i2s_clock_gen.sv
verilog/sample_fifo.sv
verilog/i2s_frame_fsm.sv
verilog/sample_shifter.sv
verilog/i2s_tx.sv
test/i2s_tx_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the i2s transmitter testbench with verilator and run it
# the exit status of the simulation is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module i2s_tx_tb -f sources.f -o i2s_tx_sim \
  && ./obj_dir/i2s_tx_sim \
  || exit 1
